// File: logic/seq_regmap_pkg.sv
// control register map of the byte-serial programming port, 0-bit command window
package seq_regmap_pkg;

    // 0-bit commands: address alone carries the value, bit 0 is the new level
    localparam logic [9:0] phy_0bit_base = 10'h020; // window base
    localparam logic [9:0] phy_0bit_mask = 10'h3f0; // bits compared against base

    // sub-addresses inside the window, bits 3..1 pick the level
    localparam logic [3:0] sub_cmda_en   = 4'h4; // command/address pins enable
    localparam logic [3:0] sub_sdrst_act = 4'h6; // memory reset level
    localparam logic [3:0] sub_cke_en    = 4'h8; // clock enable level

    // memory reset asserted until software releases it
    localparam logic dflt_ddr_rst = 1'b1;

endpackage

// File: logic/seq_cmd_pkg.sv
// sequencer command word format and the widths of the command path
package seq_cmd_pkg;

    typedef logic [31:0] cmd_word_t; // one command memory word

    // widths
    localparam int cmd_addr_w   = 10; // word address inside one memory
    localparam int run_addr_w   = 11; // msb picks the memory bank
    localparam int pause_w      = 10; // nop pause counter
    localparam int sdram_addr_w = 15; // sd_a pins
    localparam int bank_w       = 3;  // sd_ba pins

    // field positions inside cmd_word_t
    localparam int sdram_addr_lsb = 0;  // bits 14..0
    localparam int bank_lsb       = 15; // bits 17..15
    localparam int ras_bit        = 18; // active high in the word
    localparam int cas_bit        = 19;
    localparam int we_bit         = 20;
    localparam int odt_bit        = 21;
    localparam int cke_bit        = 22; // toggles the cke level
    localparam int add_pause_bit  = 23; // one nop cycle after this command

    // nop only (ras, cas, we all zero)
    localparam int pause_lsb = 0;  // pause length in address bits 9..0
    localparam int done_bit  = 10; // end of sequence

endpackage

// File: logic/cmd_deser.sv
// byte-serial address collector, pulses a write for 0-bit command window hits
`timescale 1ns/100ps

module cmd_deser import seq_regmap_pkg::*; (
    input  logic       mclk,
    input  logic       rst,
    input  logic [7:0] cmd_ad,   // low byte with stb, then bits 9..8
    input  logic       cmd_stb,
    output logic [3:0] sub_addr, // valid with write
    output logic       write
);

    logic       hi_byte;   // second byte on cmd_ad now
    logic [7:0] addr_lo;   // first byte
    logic [9:0] full_addr;
    logic       hit;

    assign full_addr = {cmd_ad[1:0], addr_lo};
    assign hit       = ((full_addr ^ phy_0bit_base) & phy_0bit_mask) == 10'h000;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            hi_byte <= 1'b0;
            write   <= 1'b0;
        end else begin
            hi_byte <= cmd_stb;        // one byte after the strobe
            write   <= hi_byte && hit; // single cycle pulse
        end
    end

    always_ff @(posedge mclk) begin
        if (cmd_stb) begin
            addr_lo <= cmd_ad;
        end
        if (hi_byte) begin
            sub_addr <= full_addr[3:0]; // held until the next command
        end
    end

endmodule

// File: logic/phy_ctrl_regs.sv
// control levels for the memory pins, set and cleared by 0-bit commands
`timescale 1ns/100ps

module phy_ctrl_regs import seq_regmap_pkg::*; (
    input  logic       mclk,
    input  logic       rst,
    input  logic [7:0] cmd_ad,
    input  logic       cmd_stb,
    output logic       cmda_en, // command/address pins enabled
    output logic       ddr_rst, // active high memory reset
    output logic       ddr_cke  // base cke level
);

    logic [3:0] sub_addr;
    logic       write;

    cmd_deser u_deser (
        .mclk     (mclk),
        .rst      (rst),
        .cmd_ad   (cmd_ad),
        .cmd_stb  (cmd_stb),
        .sub_addr (sub_addr),
        .write    (write)
    );

    // even/odd sub-address pair per level, lsb is the value
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            cmda_en <= 1'b0;
            ddr_rst <= dflt_ddr_rst;
            ddr_cke <= 1'b0;
        end else if (write) begin
            if (sub_addr[3:1] == sub_cmda_en[3:1]) begin
                cmda_en <= sub_addr[0];
            end
            if (sub_addr[3:1] == sub_sdrst_act[3:1]) begin
                ddr_rst <= sub_addr[0];
            end
            if (sub_addr[3:1] == sub_cke_en[3:1]) begin
                ddr_cke <= sub_addr[0];
            end
        end
    end

endmodule

// File: logic/cmd_seq_mem.sv
// command sequence memory, single clock, registered read with enable
`timescale 1ns/100ps

module cmd_seq_mem import seq_cmd_pkg::*; #(
    parameter int depth_w = 10 // address bits, 2**depth_w words
) (
    input  logic               mclk,
    input  logic [depth_w-1:0] waddr,
    input  logic               we,
    input  cmd_word_t          wdata,
    input  logic [depth_w-1:0] raddr,
    input  logic               ren,   // holds rdata while low
    output cmd_word_t          rdata  // one cycle after ren
);

    cmd_word_t mem [2**depth_w];

    always_ff @(posedge mclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // output register only moves on an enabled read, so a stall keeps the word
    always_ff @(posedge mclk) begin
        if (ren) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// File: logic/seq_fetch.sv
// sequence fetcher: run/busy control, word address, pause counting and done detection
`timescale 1ns/100ps

module seq_fetch import seq_cmd_pkg::*; (
    input  logic                  mclk,
    input  logic                  rst,
    input  logic                  ddr_rst,   // clears a running sequence
    input  logic [run_addr_w-1:0] run_addr,  // msb picks bank 1
    input  logic                  run_seq,
    input  logic                  cmd0_we,
    input  logic [cmd_addr_w-1:0] cmd0_addr,
    input  cmd_word_t             cmd0_data,
    input  logic                  cmd1_we,
    input  logic [cmd_addr_w-1:0] cmd1_addr,
    input  cmd_word_t             cmd1_data,
    input  logic                  is_nop,    // decoded fields of cmd_word
    input  logic                  add_pause_req,
    input  logic [pause_w-1:0]    pause_len,
    input  logic                  done_word,
    output cmd_word_t             cmd_word,
    output logic                  cmd_valid,
    output logic                  run_busy,
    output logic                  run_done
);

    logic [2:0]            busy;       // bit 0 first, 2 once the pipe is full
    logic [cmd_addr_w-1:0] cmd_addr;   // next word to read
    logic                  cmd_sel;    // 0 manual, 1 automatic bank
    logic [pause_w-1:0]    pause_cntr;
    logic                  done_seen;  // done word just went to the pins
    logic                  start;
    logic                  pause;
    logic                  stop;
    logic                  fetch_en;
    logic                  ren0;
    logic                  ren1;
    cmd_word_t             word0;
    cmd_word_t             word1;

    assign start    = run_seq && !ddr_rst && !busy[0]; // no restart while running
    assign stop     = (cmd_valid && done_word) || done_seen;
    // fresh word decides on its own, otherwise the nop counter holds the fetch
    assign pause    = cmd_valid ? (add_pause_req || (is_nop && (pause_len != '0)))
                                : (busy[2] && (pause_cntr[pause_w-1:1] != '0));
    assign fetch_en = busy[0] && !pause && !stop;
    assign ren0     = fetch_en && !cmd_sel;
    assign ren1     = fetch_en && cmd_sel;
    assign cmd_word = cmd_sel ? word1 : word0;
    assign run_busy = busy[0];

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            busy       <= '0;
            cmd_valid  <= 1'b0;
            done_seen  <= 1'b0;
            run_done   <= 1'b0;
        end else if (ddr_rst) begin
            busy       <= '0;   // memory reset aborts the run
            cmd_valid  <= 1'b0;
            done_seen  <= 1'b0;
            run_done   <= 1'b0;
        end else begin
            busy      <= done_seen ? 3'b000 : {busy[1:0], start | busy[0]};
            cmd_valid <= fetch_en;                       // rdata valid next cycle
            done_seen <= cmd_valid && done_word && !done_seen;
            run_done  <= done_seen;                      // same edge busy drops
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            pause_cntr <= '0;
        end else if (!busy[1]) begin
            pause_cntr <= '0;
        end else if (cmd_valid && is_nop) begin
            pause_cntr <= pause_len;         // n extra nop cycles
        end else if (pause_cntr != '0) begin
            pause_cntr <= pause_cntr - 1'b1;
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            cmd_addr <= '0;
            cmd_sel  <= 1'b0;
        end else if (start) begin
            cmd_addr <= run_addr[cmd_addr_w-1:0];
            cmd_sel  <= run_addr[cmd_addr_w];
        end else if (fetch_en) begin
            cmd_addr <= cmd_addr + 1'b1;      // wraps inside the bank
        end
    end

    // manual sequences
    cmd_seq_mem #(
        .depth_w (cmd_addr_w)
    ) u_mem0 (
        .mclk  (mclk),
        .waddr (cmd0_addr),
        .we    (cmd0_we),
        .wdata (cmd0_data),
        .raddr (cmd_addr),
        .ren   (ren0),
        .rdata (word0)
    );

    // automatic sequences
    cmd_seq_mem #(
        .depth_w (cmd_addr_w)
    ) u_mem1 (
        .mclk  (mclk),
        .waddr (cmd1_addr),
        .we    (cmd1_we),
        .wdata (cmd1_data),
        .raddr (cmd_addr),
        .ren   (ren1),
        .rdata (word1)
    );

endmodule

// File: logic/cmd_issue.sv
// issue stage: decodes the command word and registers the memory command pins
`timescale 1ns/100ps

module cmd_issue import seq_cmd_pkg::*; (
    input  logic                    mclk,
    input  logic                    rst,
    input  cmd_word_t               cmd_word,
    input  logic                    cmd_valid,
    input  logic                    cmda_en,
    input  logic                    ddr_rst,
    input  logic                    ddr_cke,
    output logic                    is_nop,        // ras, cas, we all zero
    output logic                    add_pause_req,
    output logic [pause_w-1:0]      pause_len,     // meaningful for nop only
    output logic                    done_word,
    output logic [sdram_addr_w-1:0] sd_a,
    output logic [bank_w-1:0]       sd_ba,
    output logic                    sd_ras_n,
    output logic                    sd_cas_n,
    output logic                    sd_we_n,
    output logic                    sd_odt,
    output logic                    sd_cke,
    output logic                    sd_rst_n
);

    logic en; // word goes out on the pins

    assign is_nop        = !(cmd_word[ras_bit] || cmd_word[cas_bit] || cmd_word[we_bit]);
    assign add_pause_req = cmd_word[add_pause_bit];
    assign pause_len     = cmd_word[pause_lsb +: pause_w];
    assign done_word     = is_nop && cmd_word[done_bit];
    assign en            = cmd_valid && cmda_en;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            sd_a     <= '0;
            sd_ba    <= '0;
            sd_ras_n <= 1'b1; // nop
            sd_cas_n <= 1'b1;
            sd_we_n  <= 1'b1;
            sd_odt   <= 1'b0;
            sd_cke   <= 1'b0;
            sd_rst_n <= 1'b0; // memory held in reset
        end else begin
            sd_a     <= en ? cmd_word[sdram_addr_lsb +: sdram_addr_w] : '0;
            sd_ba    <= en ? cmd_word[bank_lsb +: bank_w] : '0;
            sd_ras_n <= !(en && cmd_word[ras_bit]);
            sd_cas_n <= !(en && cmd_word[cas_bit]);
            sd_we_n  <= !(en && cmd_word[we_bit]);
            sd_odt   <= en && cmd_word[odt_bit];
            sd_cke   <= ddr_cke ^ (cmd_valid && cmd_word[cke_bit]); // per-command toggle
            sd_rst_n <= !ddr_rst;
        end
    end

endmodule

// File: logic/ddr_seq_top.sv
// DDR3 command sequencer top: control registers, fetcher and pin issue stage
`timescale 1ns/100ps

module ddr_seq_top import seq_cmd_pkg::*; (
    input  logic                    mclk,
    input  logic                    rst,
    input  logic [7:0]              cmd_ad,    // byte-serial programming port
    input  logic                    cmd_stb,
    input  logic                    cmd0_we,   // manual sequence memory
    input  logic [cmd_addr_w-1:0]   cmd0_addr,
    input  cmd_word_t               cmd0_data,
    input  logic                    cmd1_we,   // automatic sequence memory
    input  logic [cmd_addr_w-1:0]   cmd1_addr,
    input  cmd_word_t               cmd1_data,
    input  logic [run_addr_w-1:0]   run_addr,
    input  logic                    run_seq,
    output logic                    run_busy,
    output logic                    run_done,
    output logic [sdram_addr_w-1:0] sd_a,
    output logic [bank_w-1:0]       sd_ba,
    output logic                    sd_ras_n,
    output logic                    sd_cas_n,
    output logic                    sd_we_n,
    output logic                    sd_odt,
    output logic                    sd_cke,
    output logic                    sd_rst_n
);

    logic               cmda_en;
    logic               ddr_rst;
    logic               ddr_cke;
    cmd_word_t          cmd_word;      // fetched word
    logic               cmd_valid;
    logic               is_nop;        // decoded back to the fetcher
    logic               add_pause_req;
    logic [pause_w-1:0] pause_len;
    logic               done_word;

    phy_ctrl_regs u_regs (
        .mclk    (mclk),
        .rst     (rst),
        .cmd_ad  (cmd_ad),
        .cmd_stb (cmd_stb),
        .cmda_en (cmda_en),
        .ddr_rst (ddr_rst),
        .ddr_cke (ddr_cke)
    );

    seq_fetch u_fetch (
        .mclk          (mclk),
        .rst           (rst),
        .ddr_rst       (ddr_rst),
        .run_addr      (run_addr),
        .run_seq       (run_seq),
        .cmd0_we       (cmd0_we),
        .cmd0_addr     (cmd0_addr),
        .cmd0_data     (cmd0_data),
        .cmd1_we       (cmd1_we),
        .cmd1_addr     (cmd1_addr),
        .cmd1_data     (cmd1_data),
        .is_nop        (is_nop),
        .add_pause_req (add_pause_req),
        .pause_len     (pause_len),
        .done_word     (done_word),
        .cmd_word      (cmd_word),
        .cmd_valid     (cmd_valid),
        .run_busy      (run_busy),
        .run_done      (run_done)
    );

    cmd_issue u_issue (
        .mclk          (mclk),
        .rst           (rst),
        .cmd_word      (cmd_word),
        .cmd_valid     (cmd_valid),
        .cmda_en       (cmda_en),
        .ddr_rst       (ddr_rst),
        .ddr_cke       (ddr_cke),
        .is_nop        (is_nop),
        .add_pause_req (add_pause_req),
        .pause_len     (pause_len),
        .done_word     (done_word),
        .sd_a          (sd_a),
        .sd_ba         (sd_ba),
        .sd_ras_n      (sd_ras_n),
        .sd_cas_n      (sd_cas_n),
        .sd_we_n       (sd_we_n),
        .sd_odt        (sd_odt),
        .sd_cke        (sd_cke),
        .sd_rst_n      (sd_rst_n)
    );

endmodule

// File: tests/ddr_seq_properties.sv
// protocol assertions on the run port and the command pins of the sequencer top
`timescale 1ns/100ps

module ddr_seq_properties (
    input logic mclk,
    input logic rst,
    input logic ddr_rst,
    input logic cmda_en,
    input logic run_busy,
    input logic run_done,
    input logic sd_ras_n,
    input logic sd_cas_n,
    input logic sd_we_n
);

    int fail_cnt = 0; // failed assertions so far

    property p_done_pulse;
        @(posedge mclk) disable iff (rst) run_done |=> !run_done; // single cycle
    endproperty

    property p_done_ends_busy;
        @(posedge mclk) disable iff (rst) $rose(run_done) |-> $fell(run_busy);
    endproperty

    // memory reset blocks and aborts runs
    property p_idle_in_reset;
        @(posedge mclk) disable iff (rst) ddr_rst |=> !run_busy;
    endproperty

    property p_nop_when_off;
        @(posedge mclk) disable iff (rst) !cmda_en |=> (sd_ras_n && sd_cas_n && sd_we_n);
    endproperty

    a_done_pulse: assert property (p_done_pulse) else begin
        $error("run_done held high for more than one cycle");
        fail_cnt = fail_cnt + 1;
    end

    a_done_ends_busy: assert property (p_done_ends_busy) else begin
        $error("run_done rose without run_busy falling in the same cycle");
        fail_cnt = fail_cnt + 1;
    end

    a_idle_in_reset: assert property (p_idle_in_reset) else begin
        $error("run_busy high while memory reset is active");
        fail_cnt = fail_cnt + 1;
    end

    a_nop_when_off: assert property (p_nop_when_off) else begin
        $error("command pins not NOP while command/address is disabled");
        fail_cnt = fail_cnt + 1;
    end

endmodule

bind ddr_seq_top ddr_seq_properties u_props (
    .mclk     (mclk),
    .rst      (rst),
    .ddr_rst  (ddr_rst),
    .cmda_en  (cmda_en),
    .run_busy (run_busy),
    .run_done (run_done),
    .sd_ras_n (sd_ras_n),
    .sd_cas_n (sd_cas_n),
    .sd_we_n  (sd_we_n)
);

// File: tests/ddr_seq_tb.sv
// testbench for the DDR3 command sequencer, pin-by-pin scoreboard and closing report
`timescale 1ns/100ps

module ddr_seq_tb
    import seq_cmd_pkg::*;
    import seq_regmap_pkg::*;
();

    localparam int clk_period = 100;
    localparam int n_off      = 8;  // commands run with cmd/addr disabled
    localparam int n_bank0    = 24;
    localparam int n_bank1    = 16;
    localparam int n_mixed    = 8;  // commands in the pause test
    localparam int max_start  = 10; // highest bank 1 start word
    localparam int seq_words  = (n_off + 1) + (n_bank0 + 1) + (max_start + n_bank1 + 1)
                              + (2 * n_mixed + 1);
    localparam int watchdog_cycles = 2 * seq_words + 17 * n_mixed + 200; // load + play + pauses

    logic                    mclk;
    logic                    rst;
    logic [7:0]              cmd_ad;
    logic                    cmd_stb;
    logic                    cmd0_we;
    logic [cmd_addr_w-1:0]   cmd0_addr;
    cmd_word_t               cmd0_data;
    logic                    cmd1_we;
    logic [cmd_addr_w-1:0]   cmd1_addr;
    cmd_word_t               cmd1_data;
    logic [run_addr_w-1:0]   run_addr;
    logic                    run_seq;
    logic                    run_busy;
    logic                    run_done;
    logic [sdram_addr_w-1:0] sd_a;
    logic [bank_w-1:0]       sd_ba;
    logic                    sd_ras_n;
    logic                    sd_cas_n;
    logic                    sd_we_n;
    logic                    sd_odt;
    logic                    sd_cke;
    logic                    sd_rst_n;

    logic [31:0] lfsr;
    int          err_cnt;
    logic        exp_cmda_en;  // model of the control levels
    logic        exp_ddr_rst;
    logic        exp_ddr_cke;
    cmd_word_t   seq_buf [$];  // words to load
    logic [25:0] exp_q [$];    // {busy, done, a, ba, ras_n, cas_n, we_n, odt, cke, rst_n}

    ddr_seq_top u_dut (.*);

    always #(clk_period / 2) mclk = ~mclk;

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r[i] = lfsr[0];
        end
        return r;
    endfunction

    function automatic cmd_word_t rand_cmd(input logic add_pause);
        cmd_word_t w;
        w = rand_bits(23);                          // addr, bank, ras/cas/we, odt, cke
        if (w[we_bit:ras_bit] == 3'b000) begin
            w[cas_bit] = 1'b1;                      // keep it a real command
        end
        w[add_pause_bit] = add_pause;
        return w;
    endfunction

    function automatic cmd_word_t nop_word(input logic [9:0] len, input logic done);
        cmd_word_t w;
        w = '0;
        w[pause_lsb +: pause_w] = len;
        w[done_bit]             = done;
        return w;
    endfunction

    // expected pins one cycle after the issue stage sees (w, valid)
    function automatic logic [25:0] exp_pins(input cmd_word_t w, input logic valid,
                                             input logic busy, input logic done);
        logic en;
        en = valid && exp_cmda_en;
        return {busy, done,
                en ? w[sdram_addr_lsb +: sdram_addr_w] : 15'h0000,
                en ? w[bank_lsb +: bank_w] : 3'b000,
                !(en && w[ras_bit]), !(en && w[cas_bit]), !(en && w[we_bit]),
                en && w[odt_bit],
                exp_ddr_cke ^ (valid && w[cke_bit]),
                !exp_ddr_rst};
    endfunction

    task automatic check_pins(input logic [25:0] exp_e, input string tag);
        logic [25:0] got;
        got = {run_busy, run_done, sd_a, sd_ba, sd_ras_n, sd_cas_n, sd_we_n,
               sd_odt, sd_cke, sd_rst_n};
        assert (got === exp_e) else begin
            err_cnt++;
            $display("Mismatch at %0t: %s pins %h, expected %h", $time, tag, got, exp_e);
        end
    endtask

    // two-byte address on the serial port, then wait for the level and the pins
    task automatic send_addr(input logic [9:0] addr);
        cmd_ad  = addr[7:0];
        cmd_stb = 1'b1;
        @(negedge mclk);
        cmd_ad  = {6'b000000, addr[9:8]};
        cmd_stb = 1'b0;
        @(negedge mclk);
        cmd_ad  = 8'h00;
        repeat (3) @(negedge mclk);
        if ((addr & phy_0bit_mask) == (phy_0bit_base & phy_0bit_mask)) begin
            if (addr[3:1] == sub_cmda_en[3:1]) exp_cmda_en = addr[0];
            if (addr[3:1] == sub_sdrst_act[3:1]) exp_ddr_rst = addr[0];
            if (addr[3:1] == sub_cke_en[3:1]) exp_ddr_cke = addr[0];
        end
        check_pins(exp_pins('0, 1'b0, 1'b0, 1'b0), "level");
    endtask

    task automatic set_level(input logic [3:0] sub, input logic val);
        send_addr(phy_0bit_base | {6'b000000, sub[3:1], val});
    endtask

    task automatic write_mem(input logic bank, input logic [9:0] start);
        int         i;
        logic [9:0] a;
        for (i = 0; i < seq_buf.size(); i++) begin
            a         = start + i[9:0];
            cmd0_we   = !bank;
            cmd1_we   = bank;
            cmd0_addr = bank ? ~a : a;                   // idle port carries the inverse
            cmd1_addr = bank ? a : ~a;
            cmd0_data = bank ? ~seq_buf[i] : seq_buf[i];
            cmd1_data = bank ? seq_buf[i] : ~seq_buf[i];
            @(negedge mclk);
        end
        cmd0_we = 1'b0;
        cmd1_we = 1'b0;
    endtask

    // pin trace per cycle: word, then its pause cycles, done pulse, idle
    task automatic build_expected();
        cmd_word_t w;
        logic      nop;
        int        i;
        exp_q = {};
        for (i = 0; i < seq_buf.size(); i++) begin
            w   = seq_buf[i];
            nop = !(w[ras_bit] || w[cas_bit] || w[we_bit]);
            exp_q.push_back(exp_pins(w, 1'b1, 1'b1, 1'b0));
            if (nop && w[done_bit]) begin
                exp_q.push_back(exp_pins('0, 1'b0, 1'b0, 1'b1)); // busy falls with done
                exp_q.push_back(exp_pins('0, 1'b0, 1'b0, 1'b0));
                break;
            end
            if (nop) begin
                repeat (w[pause_lsb +: pause_w]) exp_q.push_back(exp_pins('0, 1'b0, 1'b1, 1'b0));
            end else if (w[add_pause_bit]) begin
                exp_q.push_back(exp_pins('0, 1'b0, 1'b1, 1'b0));
            end
        end
    endtask

    task automatic run_and_check(input logic [10:0] addr, input string tag);
        build_expected();
        run_addr = addr;
        run_seq  = 1'b1;
        @(negedge mclk);
        run_seq  = 1'b0;
        repeat (2) @(negedge mclk); // first word reaches the pins 3 cycles after run_seq
        while (exp_q.size() > 0) begin
            check_pins(exp_q.pop_front(), tag);
            @(negedge mclk);
        end
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Timeout: run still going after %0d clock cycles", watchdog_cycles);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int          i;
        logic [31:0] r;
        logic [9:0]  start;
        lfsr        = 32'hcdd4;
        err_cnt     = 0;
        exp_cmda_en = 1'b0;
        exp_ddr_rst = dflt_ddr_rst;
        exp_ddr_cke = 1'b0;
        mclk        = 1'b0;
        rst         = 1'b1;
        cmd_ad      = 8'h00;
        cmd_stb     = 1'b0;
        cmd0_we     = 1'b0;
        cmd0_addr   = '0;
        cmd0_data   = '0;
        cmd1_we     = 1'b0;
        cmd1_addr   = '0;
        cmd1_data   = '0;
        run_addr    = '0;
        run_seq     = 1'b0;
        repeat (5) @(posedge mclk);
        @(negedge mclk);
        rst = 1'b0;
        @(negedge mclk);
        check_pins(exp_pins('0, 1'b0, 1'b0, 1'b0), "reset");

        // run request while the memory is held in reset
        run_seq = 1'b1;
        @(negedge mclk);
        run_seq = 1'b0;
        repeat (3) begin
            check_pins(exp_pins('0, 1'b0, 1'b0, 1'b0), "run in reset");
            @(negedge mclk);
        end

        set_level(sub_sdrst_act, 1'b0);
        set_level(sub_cke_en, 1'b1);
        set_level(sub_sdrst_act, 1'b1);
        set_level(sub_sdrst_act, 1'b0);
        set_level(sub_cke_en, 1'b0);
        set_level(sub_cke_en, 1'b1);
        send_addr(10'h10d);              // outside the window, no effect

        // cmd/addr still disabled, pins stay NOP
        seq_buf = {};
        for (i = 0; i < n_off; i++) seq_buf.push_back(rand_cmd(1'b0));
        seq_buf.push_back(nop_word(10'd0, 1'b1));
        write_mem(1'b0, 10'd0);
        run_and_check(11'h000, "cmda off");

        set_level(sub_cmda_en, 1'b1);
        seq_buf = {};
        for (i = 0; i < n_bank0; i++) seq_buf.push_back(rand_cmd(1'b0));
        seq_buf.push_back(nop_word(10'd0, 1'b1));
        write_mem(1'b0, 10'd0);
        run_and_check(11'h000, "bank 0");

        // bank 1 from a nonzero start, words below it must not play
        r     = rand_bits(3);
        start = r[9:0] + 10'd3;
        seq_buf = {};
        for (i = 0; i < start; i++) seq_buf.push_back(rand_cmd(1'b0));
        write_mem(1'b1, 10'd0);
        seq_buf = {};
        for (i = 0; i < n_bank1; i++) seq_buf.push_back(rand_cmd(1'b0));
        seq_buf.push_back(nop_word(10'd0, 1'b1));
        write_mem(1'b1, start);
        run_and_check({1'b1, start}, "bank 1");

        // add pause and nop pause lengths, cke level low
        set_level(sub_cke_en, 1'b0);
        seq_buf = {};
        for (i = 0; i < n_mixed; i++) begin
            seq_buf.push_back(rand_cmd(i[0]));
            if (i % 3 != 2) begin
                r = rand_bits(4);
                seq_buf.push_back(nop_word(r[9:0] + 10'd1, 1'b0));
            end
        end
        seq_buf.push_back(nop_word(10'd0, 1'b1));
        write_mem(1'b0, 10'd100);
        run_and_check(11'd100, "pauses");

        repeat (2) @(negedge mclk);
        $display("errors: %0d pin checks, %0d properties", err_cnt, u_dut.u_props.fail_cnt);
        if (err_cnt == 0 && u_dut.u_props.fail_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: filelist.f
logic/seq_regmap_pkg.sv
logic/seq_cmd_pkg.sv
logic/cmd_deser.sv
logic/phy_ctrl_regs.sv
logic/cmd_seq_mem.sv
logic/seq_fetch.sv
logic/cmd_issue.sv
logic/ddr_seq_top.sv
tests/ddr_seq_properties.sv
tests/ddr_seq_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the sequencer testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module ddr_seq_tb -f filelist.f -o sim_ddr_seq
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_ddr_seq +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
